/* src/mips_pkg.sv */
// shared definitions for the single-cycle mips core
// field types, opcode and funct codes, operation enums and the
// control and data-memory request bundles
package mips_pkg;

   // basic data types
   typedef logic [31:0] word_t;
   typedef logic [29:0] waddr_t;
   typedef logic [4:0]  reg_idx_t;
   // bit k enables byte lane k
   typedef logic [3:0]  be_t;

   // reset value of the pc
   localparam word_t DEFAULT_TEXT_START = 32'h0040_0000;

   // primary opcodes, inst[31:26]
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_REGIMM  = 6'h01;
   localparam logic [5:0] OP_J       = 6'h02;
   localparam logic [5:0] OP_JAL     = 6'h03;
   localparam logic [5:0] OP_BEQ     = 6'h04;
   localparam logic [5:0] OP_BNE     = 6'h05;
   localparam logic [5:0] OP_BLEZ    = 6'h06;
   localparam logic [5:0] OP_BGTZ    = 6'h07;
   localparam logic [5:0] OP_ADDI    = 6'h08;
   localparam logic [5:0] OP_ADDIU   = 6'h09;
   localparam logic [5:0] OP_SLTI    = 6'h0a;
   localparam logic [5:0] OP_SLTIU   = 6'h0b;
   localparam logic [5:0] OP_ANDI    = 6'h0c;
   localparam logic [5:0] OP_ORI     = 6'h0d;
   localparam logic [5:0] OP_XORI    = 6'h0e;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LB      = 6'h20;
   localparam logic [5:0] OP_LH      = 6'h21;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_LBU     = 6'h24;
   localparam logic [5:0] OP_LHU     = 6'h25;
   localparam logic [5:0] OP_SB      = 6'h28;
   localparam logic [5:0] OP_SH      = 6'h29;
   localparam logic [5:0] OP_SW      = 6'h2b;

   // special funct codes, inst[5:0]
   localparam logic [5:0] FN_SLL     = 6'h00;
   localparam logic [5:0] FN_SRL     = 6'h02;
   localparam logic [5:0] FN_SRA     = 6'h03;
   localparam logic [5:0] FN_SLLV    = 6'h04;
   localparam logic [5:0] FN_SRLV    = 6'h06;
   localparam logic [5:0] FN_SRAV    = 6'h07;
   localparam logic [5:0] FN_JR      = 6'h08;
   localparam logic [5:0] FN_SYSCALL = 6'h0c;
   localparam logic [5:0] FN_ADD     = 6'h20;
   localparam logic [5:0] FN_ADDU    = 6'h21;
   localparam logic [5:0] FN_SUB     = 6'h22;
   localparam logic [5:0] FN_SUBU    = 6'h23;
   localparam logic [5:0] FN_AND     = 6'h24;
   localparam logic [5:0] FN_OR      = 6'h25;
   localparam logic [5:0] FN_XOR     = 6'h26;
   localparam logic [5:0] FN_NOR     = 6'h27;
   localparam logic [5:0] FN_SLT     = 6'h2a;
   localparam logic [5:0] FN_SLTU    = 6'h2b;

   // regimm rt field selects the branch flavor
   localparam reg_idx_t RT_BLTZ = 5'h00;
   localparam reg_idx_t RT_BGEZ = 5'h01;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL,
      ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_SLT, ALU_SLTU
   } alu_op_e;

   typedef enum logic [2:0] {
      BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ, BR_BLTZ, BR_BGEZ
   } br_cond_e;

   typedef enum logic [2:0] {
      LD_NONE, LD_LUI, LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU
   } load_op_e;

   typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} store_op_e;

   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JUMP_REG} pc_sel_e;

   // decode bundle, one per instruction
   typedef struct packed {
      alu_op_e   alu_op;
      logic      alu_src_imm;
      logic      reg_dst_rd;
      logic      reg_we;
      load_op_e  load_op;
      store_op_e store_op;
      br_cond_e  br_cond;
      pc_sel_e   pc_sel;
      logic      link;
      logic      halt_req;
   } ctrl_t;

   // data-memory request, answered in the same cycle
   typedef struct packed {
      waddr_t addr;
      word_t  wdata;
      be_t    be;
   } dmem_req_t;

endpackage

/* src/mips_decode.sv */
// instruction decoder
// maps one instruction word to the control bundle and the
// sign- or zero-extended immediate
`timescale 1ns/10ps

module mips_decode (
   input  mips_pkg::word_t inst,
   output mips_pkg::ctrl_t ctrl,
   output mips_pkg::word_t imm
);
   import mips_pkg::*;

   logic [5:0] opcode;
   logic [5:0] funct;
   reg_idx_t   rt;

   assign opcode = inst[31:26];
   assign funct  = inst[5:0];
   assign rt     = inst[20:16];

   // logical immediates are zero extended, everything else sign extended
   assign imm = (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI)
      ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};

   always_comb
   begin
      // defaults describe a no-op with sequential pc
      ctrl = '{alu_op: ALU_ADD, load_op: LD_NONE, store_op: ST_NONE,
               br_cond: BR_NONE, pc_sel: PC_SEQ, default: 1'b0};
      case (opcode)
         OP_SPECIAL:
         begin
            // r-type writes rd unless the funct says otherwise
            ctrl.reg_dst_rd = 1'b1;
            ctrl.reg_we     = 1'b1;
            case (funct)
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_SRL:  ctrl.alu_op = ALU_SRL;
               FN_SRA:  ctrl.alu_op = ALU_SRA;
               FN_SLLV: ctrl.alu_op = ALU_SLLV;
               FN_SRLV: ctrl.alu_op = ALU_SRLV;
               FN_SRAV: ctrl.alu_op = ALU_SRAV;
               // no overflow trap, so the signed and unsigned forms match
               FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_SLTU: ctrl.alu_op = ALU_SLTU;
               FN_JR:
               begin
                  ctrl.reg_we = 1'b0;
                  ctrl.pc_sel = PC_JUMP_REG;
               end
               // syscall and reserved functs both stop the core
               default:
               begin
                  ctrl.reg_we   = 1'b0;
                  ctrl.halt_req = 1'b1;
               end
            endcase
         end
         OP_REGIMM:
         begin
            ctrl.pc_sel = PC_BRANCH;
            if (rt == RT_BLTZ)
               ctrl.br_cond = BR_BLTZ;
            else if (rt == RT_BGEZ)
               ctrl.br_cond = BR_BGEZ;
            else
            begin
               ctrl.pc_sel   = PC_SEQ;
               ctrl.halt_req = 1'b1;
            end
         end
         OP_J:    ctrl.pc_sel = PC_JUMP;
         OP_JAL:
         begin
            // link value and r31 are chosen in the core
            ctrl.pc_sel = PC_JUMP;
            ctrl.link   = 1'b1;
            ctrl.reg_we = 1'b1;
         end
         OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
         begin
            ctrl.pc_sel  = PC_BRANCH;
            ctrl.br_cond = (opcode == OP_BEQ) ? BR_BEQ : (opcode == OP_BNE) ? BR_BNE
               : (opcode == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
         end
         OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI:
         begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_we      = 1'b1;
            ctrl.alu_op = (opcode == OP_SLTI) ? ALU_SLT : (opcode == OP_SLTIU) ? ALU_SLTU
               : (opcode == OP_ANDI) ? ALU_AND : (opcode == OP_ORI) ? ALU_OR
               : (opcode == OP_XORI) ? ALU_XOR : ALU_ADD;
         end
         // lui goes through the load path, value comes from the immediate
         OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
         begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_we      = 1'b1;
            ctrl.load_op = (opcode == OP_LUI) ? LD_LUI : (opcode == OP_LB) ? LD_LB
               : (opcode == OP_LH) ? LD_LH : (opcode == OP_LW) ? LD_LW
               : (opcode == OP_LBU) ? LD_LBU : LD_LHU;
         end
         OP_SB, OP_SH, OP_SW:
         begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.store_op = (opcode == OP_SB) ? ST_SB : (opcode == OP_SH) ? ST_SH : ST_SW;
         end
         default: ctrl.halt_req = 1'b1;
      endcase
   end

endmodule

/* src/mips_regfile.sv */
// register file, two combinational reads and one write per clock
// r0 has no storage and always reads as zero
`timescale 1ns/10ps

module mips_regfile (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::reg_idx_t  rs,
   input  mips_pkg::reg_idx_t  rt,
   input  mips_pkg::reg_idx_t  rd_idx,
   input  mips_pkg::word_t     rd_data,
   input  logic                we,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data
);
   import mips_pkg::*;

   // only r1..r31 are stored
   word_t regs [1:31];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < 32; i++)
         begin
            regs[i] <= '0;
         end
      end
      // writes aimed at r0 are dropped here
      else if (we && rd_idx != 5'd0)
      begin
         regs[rd_idx] <= rd_data;
      end
   end

   assign rs_data = (rs == 5'd0) ? '0 : regs[rs];
   assign rt_data = (rt == 5'd0) ? '0 : regs[rt];

endmodule

/* src/mips_alu.sv */
// alu with the branch condition test
// arithmetic, logic, shifts and set-less-than, plus a separate
// comparator that decides conditional branches
`timescale 1ns/10ps

module mips_alu (
   input  mips_pkg::word_t    op_a,
   input  mips_pkg::word_t    op_b,
   input  mips_pkg::alu_op_e  alu_op,
   input  mips_pkg::br_cond_e br_cond,
   input  logic [4:0]         shamt,
   output mips_pkg::word_t    alu_out,
   output logic               br_taken
);
   import mips_pkg::*;

   logic [4:0] var_sh;
   logic       a_zero;
   logic       a_neg;

   // variable shifts take the amount from rs
   assign var_sh = op_a[4:0];
   assign a_zero = (op_a == '0);
   assign a_neg  = op_a[31];

   always_comb
   begin
      case (alu_op)
         ALU_ADD:  alu_out = op_a + op_b;
         ALU_SUB:  alu_out = op_a - op_b;
         ALU_AND:  alu_out = op_a & op_b;
         ALU_OR:   alu_out = op_a | op_b;
         ALU_XOR:  alu_out = op_a ^ op_b;
         ALU_NOR:  alu_out = ~(op_a | op_b);
         // immediate shifts act on rt with the shamt field
         ALU_SLL:  alu_out = op_b << shamt;
         ALU_SRL:  alu_out = op_b >> shamt;
         ALU_SRA:  alu_out = $signed(op_b) >>> shamt;
         ALU_SLLV: alu_out = op_b << var_sh;
         ALU_SRLV: alu_out = op_b >> var_sh;
         ALU_SRAV: alu_out = $signed(op_b) >>> var_sh;
         ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: alu_out = {31'b0, op_a < op_b};
         default:  alu_out = op_a + op_b;
      endcase
   end

   // branch test runs beside the datapath, not through it
   always_comb
   begin
      case (br_cond)
         BR_BEQ:  br_taken = (op_a == op_b);
         BR_BNE:  br_taken = (op_a != op_b);
         // the zero compares look only at rs, signed
         BR_BLEZ: br_taken = a_neg | a_zero;
         BR_BGTZ: br_taken = !a_neg && !a_zero;
         BR_BLTZ: br_taken = a_neg;
         BR_BGEZ: br_taken = !a_neg;
         default: br_taken = 1'b0;
      endcase
   end

endmodule

/* src/mips_mem_align.sv */
// load/store byte lane logic
// lane k of a word is bits 8k upward and write enable bit k,
// for both stores and loads
`timescale 1ns/10ps

module mips_mem_align (
   input  mips_pkg::word_t     addr,
   input  mips_pkg::store_op_e store_op,
   input  mips_pkg::load_op_e  load_op,
   input  mips_pkg::word_t     rt_data,
   input  mips_pkg::word_t     mem_rdata,
   input  logic [15:0]         imm_hi,
   output mips_pkg::dmem_req_t req,
   output mips_pkg::word_t     load_data
);
   import mips_pkg::*;

   logic [1:0] offset;
   logic [4:0] lane_sh;
   word_t      rd_shifted;

   assign offset  = addr[1:0];
   // byte offset times eight
   assign lane_sh = {offset, 3'b000};
   assign req.addr = addr[31:2];

   always_comb
   begin
      case (store_op)
         ST_SB:
         begin
            req.wdata = {24'h0, rt_data[7:0]} << lane_sh;
            req.be    = 4'b0001 << offset;
         end
         ST_SH:
         begin
            req.wdata = {16'h0, rt_data[15:0]} << lane_sh;
            req.be    = 4'b0011 << offset;
         end
         ST_SW:
         begin
            req.wdata = rt_data;
            req.be    = 4'b1111;
         end
         default:
         begin
            req.wdata = rt_data;
            req.be    = 4'b0000;
         end
      endcase
   end

   // addressed lane moved down to bit 0
   assign rd_shifted = mem_rdata >> lane_sh;

   always_comb
   begin
      case (load_op)
         LD_LUI:  load_data = {imm_hi, 16'h0000};
         LD_LB:   load_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
         LD_LH:   load_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
         LD_LW:   load_data = mem_rdata;
         LD_LBU:  load_data = {24'h0, rd_shifted[7:0]};
         LD_LHU:  load_data = {16'h0, rd_shifted[15:0]};
         default: load_data = '0;
      endcase
   end

endmodule

/* src/mips_core.sv */
// single-cycle mips-i core, top level
// holds the pc and halt flag, picks the writeback value and the next pc
// and gates all state updates once halted
`timescale 1ns/10ps

module mips_core #(
   parameter mips_pkg::word_t TEXT_START = mips_pkg::DEFAULT_TEXT_START
) (
   input  logic                clk,
   input  logic                rst_b,
   output mips_pkg::waddr_t    inst_addr,
   input  mips_pkg::word_t     inst,
   output mips_pkg::dmem_req_t dmem_req,
   input  mips_pkg::word_t     mem_rdata,
   output logic                halted
);
   import mips_pkg::*;

   word_t     pc_q;
   logic      halted_q;
   ctrl_t     ctrl;
   word_t     imm;
   word_t     rs_data;
   word_t     rt_data;
   word_t     alu_b;
   word_t     alu_out;
   logic      br_taken;
   word_t     load_data;
   dmem_req_t align_req;
   word_t     pc_plus4;
   word_t     br_target;
   word_t     jmp_target;
   word_t     next_pc;
   reg_idx_t  wb_idx;
   word_t     wb_data;

   mips_decode i_mips_decode (.inst(inst), .ctrl(ctrl), .imm(imm));

   // a halted core must not touch the register file
   mips_regfile i_mips_regfile (
      .clk(clk), .rst_b(rst_b), .rs(inst[25:21]), .rt(inst[20:16]),
      .rd_idx(wb_idx), .rd_data(wb_data), .we(ctrl.reg_we && !halted_q),
      .rs_data(rs_data), .rt_data(rt_data)
   );

   assign alu_b = ctrl.alu_src_imm ? imm : rt_data;

   mips_alu i_mips_alu (
      .op_a(rs_data), .op_b(alu_b), .alu_op(ctrl.alu_op), .br_cond(ctrl.br_cond),
      .shamt(inst[10:6]), .alu_out(alu_out), .br_taken(br_taken)
   );

   // effective address is the alu sum of rs and the offset
   mips_mem_align i_mips_mem_align (
      .addr(alu_out), .store_op(ctrl.store_op), .load_op(ctrl.load_op),
      .rt_data(rt_data), .mem_rdata(mem_rdata), .imm_hi(imm[15:0]),
      .req(align_req), .load_data(load_data)
   );

   assign dmem_req.addr  = align_req.addr;
   assign dmem_req.wdata = align_req.wdata;
   // no memory write after halt
   assign dmem_req.be    = halted_q ? 4'b0000 : align_req.be;

   // destination is r31 for jal, else rd for r-type, else rt
   assign wb_idx  = ctrl.link ? 5'd31 : (ctrl.reg_dst_rd ? inst[15:11] : inst[20:16]);
   assign wb_data = ctrl.link ? pc_plus4
      : (ctrl.load_op != LD_NONE) ? load_data : alu_out;

   assign pc_plus4   = pc_q + 32'd4;
   assign br_target  = pc_plus4 + {imm[29:0], 2'b00};
   assign jmp_target = {pc_q[31:28], inst[25:0], 2'b00};

   always_comb
   begin
      case (ctrl.pc_sel)
         // untaken branch falls through
         PC_BRANCH:   next_pc = br_taken ? br_target : pc_plus4;
         PC_JUMP:     next_pc = jmp_target;
         PC_JUMP_REG: next_pc = rs_data;
         default:     next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc_q     <= TEXT_START;
         halted_q <= 1'b0;
      end
      else
      begin
         // halt is sticky until reset
         if (ctrl.halt_req)
            halted_q <= 1'b1;
         // pc stays on the halting instruction
         if (!halted_q && !ctrl.halt_req)
            pc_q <= next_pc;
      end
   end

   assign inst_addr = pc_q[31:2];
   assign halted    = halted_q;

endmodule

/* testbench/mips_core_assert.sv */
// concurrent checks on the core's halt behavior
// bound into mips_core by the testbench
`timescale 1ns/10ps

module mips_core_assert (
   input logic             clk,
   input logic             rst_b,
   input logic             halted,
   input mips_pkg::waddr_t inst_addr,
   input mips_pkg::be_t    be
);

   // no byte lane is written once the core has stopped
   be_off_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> be == 4'b0000)
      else $error("write enable active while halted");

   // only reset clears the halt flag
   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted)
      else $error("halted fell without reset");

   pc_held: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else $error("inst_addr moved while halted");

endmodule

/* testbench/mips_iss.svh */
// reference model and random program generator for the core testbench
// the model keeps its own pc, registers and data memory, executes one
// instruction per call and has no branch delay slot
`ifndef MIPS_ISS_SVH
`define MIPS_ISS_SVH

localparam int IMEM_WORDS = 1024;
localparam int DMEM_WORDS = 256;

// instruction pools for the generator
localparam logic [5:0] ALU_FNS [0:15] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
   FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
localparam logic [5:0] IMM_OPS [0:7] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
   OP_ORI, OP_XORI, OP_LUI};
localparam logic [5:0] LD_OPS [0:5] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LUI};
localparam logic [5:0] ST_OPS [0:2] = '{OP_SB, OP_SH, OP_SW};

integer seed = 32'h4f68;
word_t  prog [0:IMEM_WORDS-1];
int     prog_len;
word_t  m_regs [0:31];
word_t  m_dmem [0:DMEM_WORDS-1];
word_t  m_pc;
logic   m_halted;

function automatic int rnd(input int n);
   return $unsigned($random(seed)) % n;
endfunction

function automatic word_t enc_r(input logic [5:0] fn, input reg_idx_t rs, input reg_idx_t rt,
                                input reg_idx_t rd, input logic [4:0] sh);
   return {OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input reg_idx_t rs, input reg_idx_t rt,
                                input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// idx is the word index of the target inside the text segment
function automatic word_t enc_j(input logic [5:0] op, input int idx);
   return {op, 26'((DEFAULT_TEXT_START >> 2) + idx)};
endfunction

// byte offset below 1024, naturally aligned for the access size
function automatic logic [15:0] aligned_off(input logic [5:0] op);
   logic [15:0] off;
   off = 16'(rnd(1024));
   if (op == OP_LH || op == OP_LHU || op == OP_SH)
      off[0] = 1'b0;
   if (op == OP_LW || op == OP_SW)
      off[1:0] = 2'b00;
   return off;
endfunction

task automatic emit(input word_t w);
   prog[prog_len] = w;
   prog_len++;
endtask

// random register or immediate alu instruction writing dst
task automatic gen_alu(input reg_idx_t dst);
   reg_idx_t rs;
   reg_idx_t rt;
   rs = reg_idx_t'(rnd(30));
   rt = reg_idx_t'(rnd(30));
   if (rnd(2) == 0)
      emit(enc_r(ALU_FNS[rnd(16)], rs, rt, dst, 5'(rnd(32))));
   else
      emit(enc_i(IMM_OPS[rnd(8)], rs, dst, 16'($random(seed))));
endtask

// one forward transfer of control, the slots after it may be skipped
task automatic gen_flow();
   int here;
   int c;
   here = prog_len;
   c = rnd(6);
   case (rnd(4))
      0:
      begin
         // conditional branch over 0 to 2 filler slots
         if (c < 4)
            emit(enc_i(OP_BEQ + 6'(c), reg_idx_t'(rnd(30)), reg_idx_t'(rnd(30)),
                       16'(rnd(3))));
         else
            emit(enc_i(OP_REGIMM, reg_idx_t'(rnd(30)), reg_idx_t'(c - 4), 16'(rnd(3))));
         gen_alu(reg_idx_t'(1 + rnd(29)));
         gen_alu(reg_idx_t'(1 + rnd(29)));
      end
      1:
      begin
         emit(enc_j(OP_J, here + 1 + rnd(3)));
         gen_alu(reg_idx_t'(1 + rnd(29)));
         gen_alu(reg_idx_t'(1 + rnd(29)));
      end
      2:
      begin
         // return address is stored where the jal lands
         emit(enc_j(OP_JAL, here + 2));
         gen_alu(reg_idx_t'(1 + rnd(29)));
         emit(enc_i(OP_SW, 5'd0, 5'd31, aligned_off(OP_SW)));
      end
      default:
      begin
         // r30 gets a forward target right before the jr, the filler is skipped
         emit(enc_i(OP_LUI, 5'd0, 5'd30, DEFAULT_TEXT_START[31:16]));
         emit(enc_i(OP_ORI, 5'd30, 5'd30, 16'(4 * (here + 4))));
         emit(enc_r(FN_JR, 5'd30, 5'd0, 5'd0, 5'd0));
         gen_alu(reg_idx_t'(1 + rnd(29)));
      end
   endcase
endtask

// kind 0 alu, 1 stores, 2 loads, 3 control flow
task automatic build_program(input int kind);
   int         i;
   reg_idx_t   dst;
   logic [5:0] op;
   // unused words hold a reserved opcode tagged with their index
   for (i = 0; i < IMEM_WORDS; i++)
      prog[i] = {6'h3f, 16'h0000, 10'(i)};
   prog_len = 0;
   if (kind == 1 || kind == 3)
   begin
      for (i = 0; i < 12; i++)
         gen_alu(reg_idx_t'(1 + rnd(29)));
   end
   for (i = 0; i < 40; i++)
   begin
      case (kind)
         0:
         begin
            // few registers so results feed each other, r0 included
            dst = reg_idx_t'(rnd(8));
            gen_alu(dst);
            emit(enc_i(OP_SW, 5'd0, dst, aligned_off(OP_SW)));
         end
         1:
         begin
            op = ST_OPS[rnd(3)];
            emit(enc_i(op, 5'd0, reg_idx_t'(rnd(30)), aligned_off(op)));
         end
         2:
         begin
            op  = LD_OPS[rnd(6)];
            dst = reg_idx_t'(rnd(30));
            emit(enc_i(op, 5'd0, dst, aligned_off(op)));
            emit(enc_i(OP_SW, 5'd0, dst, aligned_off(OP_SW)));
         end
         default: gen_flow();
      endcase
   end
   // even kinds stop on syscall, odd kinds on a reserved opcode
   emit((kind % 2 == 0) ? {OP_SPECIAL, 20'h0, FN_SYSCALL} : {6'h3e, 26'h0});
endtask

// executes the instruction at m_pc, returns the expected store request
task automatic iss_step(output be_t be, output word_t wdata, output waddr_t addr);
   word_t      ins;
   word_t      a;
   word_t      b;
   word_t      r;
   word_t      w;
   word_t      ea;
   word_t      simm;
   word_t      bt;
   word_t      npc;
   logic [5:0] op;
   reg_idx_t   rt;
   reg_idx_t   dst;
   logic       wr;
   int         lane;
   int         size;
   int         k;
   be    = '0;
   wdata = '0;
   addr  = '0;
   if (m_halted)
      return;
   ins  = prog[m_pc[11:2]];
   op   = ins[31:26];
   rt   = ins[20:16];
   a    = m_regs[ins[25:21]];
   b    = m_regs[rt];
   simm = {{16{ins[15]}}, ins[15:0]};
   ea   = a + simm;
   npc  = m_pc + 4;
   bt   = npc + (simm << 2);
   // loads see the addressed lane at bit 0
   w    = m_dmem[ea[9:2]] >> (8 * ea[1:0]);
   lane = ea[1:0];
   wr   = 1'b1;
   dst  = rt;
   r    = '0;
   case (op)
      OP_SPECIAL:
      begin
         dst = ins[15:11];
         case (ins[5:0])
            FN_SLL:  r = b << ins[10:6];
            FN_SRL:  r = b >> ins[10:6];
            FN_SRA:  r = $signed(b) >>> ins[10:6];
            FN_SLLV: r = b << a[4:0];
            FN_SRLV: r = b >> a[4:0];
            FN_SRAV: r = $signed(b) >>> a[4:0];
            FN_ADD, FN_ADDU: r = a + b;
            FN_SUB, FN_SUBU: r = a - b;
            FN_AND:  r = a & b;
            FN_OR:   r = a | b;
            FN_XOR:  r = a ^ b;
            FN_NOR:  r = ~(a | b);
            FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            FN_JR:
            begin
               wr  = 1'b0;
               npc = a;
            end
            default:
            begin
               wr       = 1'b0;
               m_halted = 1'b1;
            end
         endcase
      end
      OP_REGIMM:
      begin
         wr = 1'b0;
         if (rt > 5'd1)
            m_halted = 1'b1;
         else if ((rt == 5'd0) == a[31])
            npc = bt;
      end
      OP_J:
      begin
         wr  = 1'b0;
         npc = {m_pc[31:28], ins[25:0], 2'b00};
      end
      OP_JAL:
      begin
         dst = 5'd31;
         r   = m_pc + 4;
         npc = {m_pc[31:28], ins[25:0], 2'b00};
      end
      OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
      begin
         wr = 1'b0;
         if ((op == OP_BEQ && a == b) || (op == OP_BNE && a != b)
             || (op == OP_BLEZ && $signed(a) <= 0) || (op == OP_BGTZ && $signed(a) > 0))
            npc = bt;
      end
      OP_ADDI, OP_ADDIU: r = a + simm;
      OP_SLTI:  r = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
      OP_SLTIU: r = (a < simm) ? 32'd1 : 32'd0;
      OP_ANDI:  r = a & {16'h0, ins[15:0]};
      OP_ORI:   r = a | {16'h0, ins[15:0]};
      OP_XORI:  r = a ^ {16'h0, ins[15:0]};
      OP_LUI:   r = {ins[15:0], 16'h0000};
      OP_LB:    r = {{24{w[7]}}, w[7:0]};
      OP_LH:    r = {{16{w[15]}}, w[15:0]};
      OP_LW:    r = w;
      OP_LBU:   r = {24'h0, w[7:0]};
      OP_LHU:   r = {16'h0, w[15:0]};
      OP_SB, OP_SH, OP_SW:
      begin
         wr   = 1'b0;
         size = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
         addr = ea[31:2];
         // lane k takes source byte k minus the offset
         for (k = 0; k < 4; k++)
         begin
            if (k >= lane && k < lane + size)
            begin
               be[k] = 1'b1;
               wdata[8*k +: 8] = b[8*(k-lane) +: 8];
               m_dmem[ea[9:2]][8*k +: 8] = b[8*(k-lane) +: 8];
            end
         end
      end
      default:
      begin
         wr       = 1'b0;
         m_halted = 1'b1;
      end
   endcase
   if (wr && dst != 5'd0)
      m_regs[dst] = r;
   // a halting instruction keeps the pc on itself
   if (!m_halted)
      m_pc = npc;
endtask

`endif

/* testbench/tb_mips_core.sv */
// testbench for the single-cycle mips core
// runs random programs against a reference model and compares the pc,
// store requests and halt flag in every cycle
`timescale 1ns/10ps

module tb_mips_core;
   import mips_pkg::*;

   `include "mips_iss.svh"

   logic      clk;
   logic      rst_b;
   waddr_t    inst_addr;
   word_t     inst;
   dmem_req_t dmem_req;
   word_t     mem_rdata;
   logic      halted;
   word_t     be_mask;
   word_t     dmem [0:DMEM_WORDS-1];
   int        errors;
   int        checks;
   int        cycles;
   int        cycle_limit;

   mips_core i_mips_core (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .dmem_req(dmem_req), .mem_rdata(mem_rdata), .halted(halted)
   );

   bind mips_core mips_core_assert i_mips_core_assert (
      .clk(clk), .rst_b(rst_b), .halted(halted), .inst_addr(inst_addr), .be(dmem_req.be)
   );

   // both memories answer in the same cycle
   assign inst      = prog[inst_addr[9:0]];
   assign mem_rdata = dmem[dmem_req.addr[7:0]];
   assign be_mask   = {{8{dmem_req.be[3]}}, {8{dmem_req.be[2]}},
                       {8{dmem_req.be[1]}}, {8{dmem_req.be[0]}}};

   // enabled lanes are written at the rising edge
   always @(posedge clk)
   begin
      if (rst_b && dmem_req.be != 4'b0000)
         dmem[dmem_req.addr[7:0]] <= (dmem[dmem_req.addr[7:0]] & ~be_mask)
                                   | (dmem_req.wdata & be_mask);
   end

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // limit grows with every generated program
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit)
      begin
         $display("timeout: run did not end within %0d cycles", cycle_limit);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_addr(input string name, input string what, input waddr_t exp,
                             input waddr_t act);
      checks++;
      if (exp !== act)
      begin
         $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (exp !== act)
      begin
         $display("Fail %s wdata: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_be(input string name, input be_t exp, input be_t act);
      checks++;
      if (exp !== act)
      begin
         $display("Fail %s be: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_halt(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act)
      begin
         $display("Fail %s halted: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   // one program from reset until a few cycles past its halt
   task automatic run_test(input string name, input int kind);
      be_t    exp_be;
      word_t  exp_wdata;
      waddr_t exp_addr;
      int     err_start;
      int     steps;
      int     tail;
      int     i;
      err_start = errors;
      steps     = 0;
      tail      = 0;
      @(negedge clk);
      rst_b = 1'b0;
      build_program(kind);
      cycle_limit += 2 * prog_len;
      for (i = 0; i < DMEM_WORDS; i++)
      begin
         m_dmem[i] = $random(seed);
         dmem[i] <= m_dmem[i];
      end
      for (i = 0; i < 32; i++)
         m_regs[i] = '0;
      m_pc     = DEFAULT_TEXT_START;
      m_halted = 1'b0;
      repeat (5) @(negedge clk);
      rst_b = 1'b1;
      // outputs are settled at the falling edge, the model steps alongside
      while (tail < 4)
      begin
         check_addr(name, "inst_addr", m_pc[31:2], inst_addr);
         check_halt(name, m_halted, halted);
         if (m_halted)
            tail++;
         iss_step(exp_be, exp_wdata, exp_addr);
         check_be(name, exp_be, dmem_req.be);
         if (exp_be != 4'b0000)
         begin
            check_word(name, exp_wdata, dmem_req.wdata);
            check_addr(name, "store addr", exp_addr, dmem_req.addr);
         end
         steps++;
         @(negedge clk);
      end
      $display("test %s done: %0d cycles, %0d errors", name, steps, errors - err_start);
   endtask

   initial
   begin
      rst_b       = 1'b0;
      errors      = 0;
      checks      = 0;
      cycle_limit = 200;
      run_test("alu", 0);
      run_test("store", 1);
      run_test("load", 2);
      run_test("branch", 3);
      $display("4 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+testbench
src/mips_pkg.sv
src/mips_decode.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_mem_align.sv
src/mips_core.sv
testbench/mips_core_assert.sv
testbench/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
# builds the core testbench with verilator, runs it and scans the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module tb_mips_core -o tb_mips_core > build.log 2>&1 &&
./obj_dir/tb_mips_core > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported errors"; exit 1; } || exit 0
